// ==== alu.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module alu (
    input  wire [`DATA_WIDTH-1:0]       a,
    input  wire [`DATA_WIDTH-1:0]       b,
    input  mips_backend_pkg::alu_op_t   op,
    output logic [`DATA_WIDTH-1:0]      result
);

    import mips_backend_pkg::*;

    localparam int HALF = `DATA_WIDTH / 2;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // Add and sub wrap, no overflow flag
    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_NOR:  result = ~(a | b);
            OP_SLT:  result = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
            OP_SLTU: result = {{(`DATA_WIDTH-1){1'b0}}, lt_unsigned};
            // Low half of the immediate moves to the top
            OP_LUI:  result = {b[HALF-1:0], {HALF{1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== barrel_shifter.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module barrel_shifter (
    input  wire [`DATA_WIDTH-1:0]       shift_in,
    input  wire [`SHAMT_WIDTH-1:0]      amount,
    input  mips_backend_pkg::shift_op_t op,
    output logic [`DATA_WIDTH-1:0]      shift_out
);

    import mips_backend_pkg::*;

    always_comb begin
        case (op)
            SH_SLL:  shift_out = shift_in << amount;
            SH_SRL:  shift_out = shift_in >> amount;
            // Sign bit fills from the top
            SH_SRA:  shift_out = $signed(shift_in) >>> amount;
            default: shift_out = shift_in;
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_stage.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module exec_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    // Issue
    input  wire                         issue_valid,
    input  wire [`REG_ADDR_WIDTH-1:0]   rs_addr,
    input  wire [`REG_ADDR_WIDTH-1:0]   rt_addr,
    input  wire [`REG_ADDR_WIDTH-1:0]   rd_addr,
    input  mips_backend_pkg::alu_op_t   alu_op,
    input  mips_backend_pkg::shift_op_t shift_op,
    input  wire [`SHAMT_WIDTH-1:0]      shamt,
    input  wire                         shamt_sel,
    input  wire                         b_sel,
    input  wire [`DATA_WIDTH-1:0]       imm,
    input  mips_backend_pkg::res_sel_t  res_sel,
    input  wire                         reg_w,
    input  wire                         mem_r,
    input  wire                         mem_w,
    input  mips_backend_pkg::mem_size_t mem_size,
    input  wire                         load_unsigned,
    input  wire [`DATA_WIDTH-1:0]       rs_data,
    input  wire [`DATA_WIDTH-1:0]       rt_data,
    // Writeback, for forwarding
    input  wire                         wb_valid,
    input  wire [`REG_ADDR_WIDTH-1:0]   wb_addr,
    input  wire [`DATA_WIDTH-1:0]       wb_data,
    // Data memory
    output logic                        mem_read,
    output logic                        mem_write,
    output logic [`DATA_WIDTH-1:0]      mem_addr,
    output logic [`DATA_WIDTH-1:0]      mem_wdata,
    output logic [`BYTE_EN_WIDTH-1:0]   mem_byte_en,
    // To MEM stage
    output logic                        mem_valid,
    output logic                        mem_reg_w,
    output logic [`REG_ADDR_WIDTH-1:0]  mem_rd_addr,
    output mips_backend_pkg::mem_size_t mem_size_q,
    output logic                        mem_unsigned_q
);

    import mips_backend_pkg::*;

    logic                       ex_valid;
    logic [`REG_ADDR_WIDTH-1:0] rs_q, rt_q, rd_q;
    alu_op_t                    alu_op_q;
    shift_op_t                  shift_op_q;
    logic [`SHAMT_WIDTH-1:0]    shamt_q;
    logic                       shamt_sel_q, b_sel_q;
    logic [`DATA_WIDTH-1:0]     imm_q, rs_val_q, rt_val_q;
    res_sel_t                   res_sel_q;
    logic                       reg_w_q, mem_r_q, mem_w_q;
    mem_size_t                  size_q;
    logic                       unsigned_q;

    fwd_sel_t                   a_fwd_sel, b_fwd_sel;
    logic [`DATA_WIDTH-1:0]     op_a, rt_fwd, op_b;
    logic [`DATA_WIDTH-1:0]     alu_out, shift_out, ex_result, st_data;
    logic [`SHAMT_WIDTH-1:0]    shift_amt;
    logic [`BYTE_EN_WIDTH-1:0]  st_byte_en;
    logic                       mem_r_r, mem_w_r;
    logic [`BYTE_EN_WIDTH-1:0]  byte_en_r;

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        rs_q        <= rs_addr;
        rt_q        <= rt_addr;
        rd_q        <= rd_addr;
        alu_op_q    <= alu_op;
        shift_op_q  <= shift_op;
        shamt_q     <= shamt;
        shamt_sel_q <= shamt_sel;
        b_sel_q     <= b_sel;
        imm_q       <= imm;
        res_sel_q   <= res_sel;
        reg_w_q     <= reg_w;
        mem_r_q     <= mem_r;
        mem_w_q     <= mem_w;
        size_q      <= mem_size;
        unsigned_q  <= load_unsigned;
        rs_val_q    <= rs_data;
        rt_val_q    <= rt_data;
    end

    ////////////////////
    // Execute
    ////////////////////

    forward_unit fwd (
        .rs_addr     ( rs_q        ),
        .rt_addr     ( rt_q        ),
        .mem_valid   ( mem_valid   ),
        .mem_reg_w   ( mem_reg_w   ),
        .mem_mem_r   ( mem_r_r     ),
        .mem_rd_addr ( mem_rd_addr ),
        .wb_valid    ( wb_valid    ),
        .wb_addr     ( wb_addr     ),
        .a_sel       ( a_fwd_sel   ),
        .b_sel       ( b_fwd_sel   )
    );

    // MEM side forwards its ALU result, which is also the memory address
    always_comb begin
        case (a_fwd_sel)
            FWD_MEM: op_a = mem_addr;
            FWD_WB:  op_a = wb_data;
            default: op_a = rs_val_q;
        endcase
        case (b_fwd_sel)
            FWD_MEM: rt_fwd = mem_addr;
            FWD_WB:  rt_fwd = wb_data;
            default: rt_fwd = rt_val_q;
        endcase
    end

    assign op_b      = b_sel_q ? imm_q : rt_fwd;
    // Variable shifts take the amount from rs
    assign shift_amt = shamt_sel_q ? op_a[`SHAMT_WIDTH-1:0] : shamt_q;

    alu alu_i (
        .a      ( op_a     ),
        .b      ( op_b     ),
        .op     ( alu_op_q ),
        .result ( alu_out  )
    );

    barrel_shifter shifter (
        .shift_in  ( rt_fwd     ),
        .amount    ( shift_amt  ),
        .op        ( shift_op_q ),
        .shift_out ( shift_out  )
    );

    assign ex_result = (res_sel_q == RES_SHIFT) ? shift_out : alu_out;

    store_align st_align (
        .addr_low     ( alu_out[1:0] ),
        .size         ( size_q       ),
        .rt_data      ( rt_fwd       ),
        .byte_en      ( st_byte_en   ),
        .aligned_data ( st_data      )
    );

    ////////////////////
    // EX/MEM register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mem_valid <= 1'b0;
        else
            mem_valid <= ex_valid;
    end

    always_ff @(posedge clk) begin
        mem_addr       <= ex_result;
        mem_wdata      <= st_data;
        byte_en_r      <= st_byte_en;
        mem_rd_addr    <= rd_q;
        mem_reg_w      <= reg_w_q;
        mem_r_r        <= mem_r_q;
        mem_w_r        <= mem_w_q;
        mem_size_q     <= size_q;
        mem_unsigned_q <= unsigned_q;
    end

    // Strobes only for a live instruction
    assign mem_read    = mem_valid && mem_r_r;
    assign mem_write   = mem_valid && mem_w_r;
    assign mem_byte_en = mem_write ? byte_en_r : '0;

endmodule

`default_nettype wire

// ==== forward_unit.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module forward_unit (
    input  wire [`REG_ADDR_WIDTH-1:0]   rs_addr,
    input  wire [`REG_ADDR_WIDTH-1:0]   rt_addr,
    input  wire                         mem_valid,
    input  wire                         mem_reg_w,
    input  wire                         mem_mem_r,
    input  wire [`REG_ADDR_WIDTH-1:0]   mem_rd_addr,
    input  wire                         wb_valid,
    input  wire [`REG_ADDR_WIDTH-1:0]   wb_addr,
    output mips_backend_pkg::fwd_sel_t  a_sel,
    output mips_backend_pkg::fwd_sel_t  b_sel
);

    import mips_backend_pkg::*;

    logic mem_ok;
    logic wb_ok;

    // A load in MEM has no data yet, so it never forwards
    assign mem_ok = mem_valid && mem_reg_w && !mem_mem_r && (mem_rd_addr != '0);
    assign wb_ok  = wb_valid && (wb_addr != '0);

    // MEM is the younger producer and wins over WB
    function automatic fwd_sel_t pick(input logic [`REG_ADDR_WIDTH-1:0] src);
        if (src == '0)
            return FWD_REG;
        if (mem_ok && (mem_rd_addr == src))
            return FWD_MEM;
        if (wb_ok && (wb_addr == src))
            return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        a_sel = pick(rs_addr);
        b_sel = pick(rt_addr);
    end

endmodule

`default_nettype wire

// ==== gpr_file.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module gpr_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [`REG_ADDR_WIDTH-1:0]   rs_addr,
    input  wire [`REG_ADDR_WIDTH-1:0]   rt_addr,
    output logic [`DATA_WIDTH-1:0]      rs_data,
    output logic [`DATA_WIDTH-1:0]      rt_data,
    input  wire                         wb_valid,
    input  wire [`REG_ADDR_WIDTH-1:0]   wb_addr,
    input  wire [`DATA_WIDTH-1:0]       wb_data
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   wr_en;

    // $0 is never written
    assign wr_en = wb_valid && (wb_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Reads see a write landing in the same cycle
    assign rs_data = (rs_addr == '0)                  ? '0      :
                     (wr_en && (wb_addr == rs_addr))  ? wb_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0)                  ? '0      :
                     (wr_en && (wb_addr == rt_addr))  ? wb_data : regs[rt_addr];

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module mem_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         mem_valid,
    input  wire                         mem_reg_w,
    input  wire                         mem_read,
    input  wire [`REG_ADDR_WIDTH-1:0]   mem_rd_addr,
    input  wire [`DATA_WIDTH-1:0]       mem_addr,
    input  mips_backend_pkg::mem_size_t mem_size,
    input  wire                         mem_unsigned,
    input  wire [`DATA_WIDTH-1:0]       mem_rdata,
    output logic                        wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0]  wb_addr,
    output logic [`DATA_WIDTH-1:0]      wb_data
);

    import mips_backend_pkg::*;

    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [`DATA_WIDTH-1:0] ld_data;
    logic [`DATA_WIDTH-1:0] result;

    ////////////////////
    // Load alignment
    ////////////////////

    always_comb begin
        case (mem_addr[1:0])
            2'd0:    ld_byte = mem_rdata[7:0];
            2'd1:    ld_byte = mem_rdata[15:8];
            2'd2:    ld_byte = mem_rdata[23:16];
            default: ld_byte = mem_rdata[31:24];
        endcase
        ld_half = mem_addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];
    end

    always_comb begin
        case (mem_size)
            SIZE_BYTE:
                ld_data = {{(`DATA_WIDTH-8){ld_byte[7] & ~mem_unsigned}}, ld_byte};
            SIZE_HALF:
                ld_data = {{(`DATA_WIDTH-16){ld_half[15] & ~mem_unsigned}}, ld_half};
            default:
                ld_data = mem_rdata;
        endcase
    end

    // Non-loads pass the EX result
    assign result = mem_read ? ld_data : mem_addr;

    ////////////////////
    // MEM/WB register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_addr  <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= mem_valid && mem_reg_w;
            wb_addr  <= mem_rd_addr;
            wb_data  <= result;
        end
    end

endmodule

`default_nettype wire

// ==== mips_backend.f ====
+incdir+.
mips_backend_pkg.sv
gpr_file.sv
forward_unit.sv
alu.sv
barrel_shifter.sv
store_align.sv
exec_stage.sv
mem_stage.sv
mips_backend.sv
tb_mips_backend.sv

// ==== mips_backend.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module mips_backend (
    input  wire                         clk,
    input  wire                         rst_n,
    // Issue
    input  wire                         issue_valid,
    input  wire [`REG_ADDR_WIDTH-1:0]   rs_addr,
    input  wire [`REG_ADDR_WIDTH-1:0]   rt_addr,
    input  wire [`REG_ADDR_WIDTH-1:0]   rd_addr,
    input  mips_backend_pkg::alu_op_t   alu_op,
    input  mips_backend_pkg::shift_op_t shift_op,
    input  wire [`SHAMT_WIDTH-1:0]      shamt,
    input  wire                         shamt_sel,
    input  wire                         b_sel,
    input  wire [`DATA_WIDTH-1:0]       imm,
    input  mips_backend_pkg::res_sel_t  res_sel,
    input  wire                         reg_w,
    input  wire                         mem_r,
    input  wire                         mem_w,
    input  mips_backend_pkg::mem_size_t mem_size,
    input  wire                         load_unsigned,
    // Data memory
    output logic                        mem_read,
    output logic                        mem_write,
    output logic [`DATA_WIDTH-1:0]      mem_addr,
    output logic [`DATA_WIDTH-1:0]      mem_wdata,
    output logic [`BYTE_EN_WIDTH-1:0]   mem_byte_en,
    input  wire [`DATA_WIDTH-1:0]       mem_rdata,
    // Writeback
    output logic                        wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0]  wb_addr,
    output logic [`DATA_WIDTH-1:0]      wb_data
);

    logic [`DATA_WIDTH-1:0]      rs_data, rt_data;
    logic                        mem_valid, mem_reg_w, mem_unsigned_q;
    logic [`REG_ADDR_WIDTH-1:0]  mem_rd_addr;
    mips_backend_pkg::mem_size_t mem_size_q;

    gpr_file regs (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .rs_addr  ( rs_addr  ),
        .rt_addr  ( rt_addr  ),
        .rs_data  ( rs_data  ),
        .rt_data  ( rt_data  ),
        .wb_valid ( wb_valid ),
        .wb_addr  ( wb_addr  ),
        .wb_data  ( wb_data  )
    );

    exec_stage ex (
        .clk            ( clk            ),
        .rst_n          ( rst_n          ),
        .issue_valid    ( issue_valid    ),
        .rs_addr        ( rs_addr        ),
        .rt_addr        ( rt_addr        ),
        .rd_addr        ( rd_addr        ),
        .alu_op         ( alu_op         ),
        .shift_op       ( shift_op       ),
        .shamt          ( shamt          ),
        .shamt_sel      ( shamt_sel      ),
        .b_sel          ( b_sel          ),
        .imm            ( imm            ),
        .res_sel        ( res_sel        ),
        .reg_w          ( reg_w          ),
        .mem_r          ( mem_r          ),
        .mem_w          ( mem_w          ),
        .mem_size       ( mem_size       ),
        .load_unsigned  ( load_unsigned  ),
        .rs_data        ( rs_data        ),
        .rt_data        ( rt_data        ),
        .wb_valid       ( wb_valid       ),
        .wb_addr        ( wb_addr        ),
        .wb_data        ( wb_data        ),
        .mem_read       ( mem_read       ),
        .mem_write      ( mem_write      ),
        .mem_addr       ( mem_addr       ),
        .mem_wdata      ( mem_wdata      ),
        .mem_byte_en    ( mem_byte_en    ),
        .mem_valid      ( mem_valid      ),
        .mem_reg_w      ( mem_reg_w      ),
        .mem_rd_addr    ( mem_rd_addr    ),
        .mem_size_q     ( mem_size_q     ),
        .mem_unsigned_q ( mem_unsigned_q )
    );

    mem_stage mem (
        .clk          ( clk            ),
        .rst_n        ( rst_n          ),
        .mem_valid    ( mem_valid      ),
        .mem_reg_w    ( mem_reg_w      ),
        .mem_read     ( mem_read       ),
        .mem_rd_addr  ( mem_rd_addr    ),
        .mem_addr     ( mem_addr       ),
        .mem_size     ( mem_size_q     ),
        .mem_unsigned ( mem_unsigned_q ),
        .mem_rdata    ( mem_rdata      ),
        .wb_valid     ( wb_valid       ),
        .wb_addr      ( wb_addr        ),
        .wb_data      ( wb_data        )
    );

endmodule

`default_nettype wire

// ==== mips_backend_defines.svh ====
`ifndef MIPS_BACKEND_DEFINES_SVH
`define MIPS_BACKEND_DEFINES_SVH

// Datapath and register file sizes
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5
`define REG_COUNT      32
`define SHAMT_WIDTH    5
`define BYTE_EN_WIDTH  4

`endif

// ==== mips_backend_pkg.sv ====
`default_nettype none

package mips_backend_pkg;

    // ALU operation, as issued with the instruction
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        SH_SLL,
        SH_SRL,
        SH_SRA
    } shift_op_t;

    // Which unit feeds the EX result
    typedef enum logic {
        RES_ALU,
        RES_SHIFT
    } res_sel_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_t;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and scan the log for a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mips_backend \
    -f mips_backend.f -o tb_mips_backend > build.log 2>&1 \
    && ./obj_dir/tb_mips_backend > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }

grep -q "sim failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "no pass message in log"; exit 1; }
exit 0

// ==== store_align.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module store_align (
    input  wire [1:0]                   addr_low,
    input  mips_backend_pkg::mem_size_t size,
    input  wire [`DATA_WIDTH-1:0]       rt_data,
    output logic [`BYTE_EN_WIDTH-1:0]   byte_en,
    output logic [`DATA_WIDTH-1:0]      aligned_data
);

    import mips_backend_pkg::*;

    // Data is copied to every lane; the enables pick the lanes that land
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                byte_en      = `BYTE_EN_WIDTH'(1) << addr_low;
                aligned_data = {(`DATA_WIDTH/8){rt_data[7:0]}};
            end
            SIZE_HALF: begin
                byte_en      = `BYTE_EN_WIDTH'(2'b11) << {addr_low[1], 1'b0};
                aligned_data = {(`DATA_WIDTH/16){rt_data[15:0]}};
            end
            default: begin
                byte_en      = '1;
                aligned_data = rt_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== tb_mips_backend.sv ====
`default_nettype none

`include "mips_backend_defines.svh"

module tb_mips_backend;

    import mips_backend_pkg::*;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic issue_valid = 1'b0, shamt_sel = 1'b0, b_sel = 1'b0, reg_w = 1'b0;
    logic mem_r = 1'b0, mem_w = 1'b0, load_unsigned = 1'b0;
    logic [`REG_ADDR_WIDTH-1:0] rs_addr = '0, rt_addr = '0, rd_addr = '0, wb_addr;
    logic [`SHAMT_WIDTH-1:0] shamt = '0;
    logic [`DATA_WIDTH-1:0] imm = '0, mem_addr, mem_wdata, mem_rdata, wb_data;
    logic [`BYTE_EN_WIDTH-1:0] mem_byte_en;
    logic mem_read, mem_write, wb_valid;
    alu_op_t alu_op = OP_ADD;
    shift_op_t shift_op = SH_SLL;
    res_sel_t res_sel = RES_ALU;
    mem_size_t mem_size = SIZE_WORD;

    logic [`DATA_WIDTH-1:0] model_regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] dmem [64];
    logic [`DATA_WIDTH-1:0] exp_mem [64];
    int cyc = 0, errors = 0, checks = 0;
    // Expected events, one entry per writeback or store
    int wb_cyc_q[$], st_cyc_q[$];
    logic [`REG_ADDR_WIDTH-1:0] wb_addr_q[$];
    logic [`DATA_WIDTH-1:0] wb_data_q[$], st_addr_q[$], st_data_q[$];
    logic [`BYTE_EN_WIDTH-1:0] st_be_q[$];

    mips_backend uut (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Data memory, answered by word address
    assign mem_rdata = dmem[mem_addr[7:2]];
    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (mem_write && mem_byte_en[i])
                dmem[mem_addr[7:2]][8*i +: 8] <= mem_wdata[8*i +: 8];
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    ////////////////////
    // Response monitor
    ////////////////////

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (wb_cyc_q.size() == 0) begin
                $display("Writeback at cycle %0d was not expected", cyc);
                errors++;
            end else begin
                check_value("wb_cycle", cyc, wb_cyc_q.pop_front());
                check_value("wb_addr", wb_addr, wb_addr_q.pop_front());
                check_value("wb_data", wb_data, wb_data_q.pop_front());
            end
        end
        if (rst_n && mem_write) begin
            if (st_cyc_q.size() == 0) begin
                $display("Memory write at cycle %0d was not expected", cyc);
                errors++;
            end else begin
                check_value("mem_write_cycle", cyc, st_cyc_q.pop_front());
                check_value("mem_addr", mem_addr, st_addr_q.pop_front());
                check_value("mem_byte_en", mem_byte_en, st_be_q.pop_front());
                check_value("mem_wdata", mem_wdata, st_data_q.pop_front());
            end
        end
    end

    function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + ~b + 1;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOR:  return ~a & ~b;
            // Signed compare via flipped sign bits
            OP_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 1 : 0;
            OP_SLTU: return (a < b) ? 1 : 0;
            default: return b << 16;
        endcase
    endfunction

    function automatic logic [31:0] shift_model(shift_op_t op, logic [31:0] v, logic [4:0] n);
        if (op == SH_SLL)
            return v << n;
        if (op == SH_SRL || !v[31])
            return v >> n;
        return (v >> n) | ~(32'hffff_ffff >> n);
    endfunction

    // Drive one instruction and record what it must produce
    task automatic issue(input alu_op_t op, input shift_op_t sop, input res_sel_t rsel,
                         input logic [4:0] rd, rs, rt, input logic bs, input logic [31:0] im,
                         input logic [4:0] sa, input logic ss, input logic rw, mr, mw,
                         input mem_size_t sz, input logic uns);
        logic [31:0] a, b, res, w;
        logic [3:0] be;
        a = model_regs[rs];
        b = bs ? im : model_regs[rt];
        res = (rsel == RES_SHIFT) ? shift_model(sop, model_regs[rt], ss ? a[4:0] : sa)
                                  : alu_model(op, a, b);
        @(posedge clk);
        issue_valid <= 1'b1;
        alu_op <= op;
        shift_op <= sop;
        res_sel <= rsel;
        rd_addr <= rd;
        rs_addr <= rs;
        rt_addr <= rt;
        b_sel <= bs;
        imm <= im;
        shamt <= sa;
        shamt_sel <= ss;
        reg_w <= rw;
        mem_r <= mr;
        mem_w <= mw;
        mem_size <= sz;
        load_unsigned <= uns;
        @(negedge clk);
        w = exp_mem[res[7:2]];
        if (mr) begin
            if (sz == SIZE_BYTE)
                w = (w >> (8 * res[1:0])) & 32'hff;
            else if (sz == SIZE_HALF)
                w = (w >> (16 * res[1])) & 32'hffff;
            if (!uns && sz == SIZE_BYTE && w[7])
                w = w | 32'hffff_ff00;
            if (!uns && sz == SIZE_HALF && w[15])
                w = w | 32'hffff_0000;
            res = w;
        end
        if (mw) begin
            be = (sz == SIZE_WORD) ? 4'hf : (sz == SIZE_HALF) ? (res[1] ? 4'hc : 4'h3)
                                                              : 4'h1 << res[1:0];
            w = (sz == SIZE_WORD) ? model_regs[rt] : (sz == SIZE_HALF)
                ? {2{model_regs[rt][15:0]}} : {4{model_regs[rt][7:0]}};
            for (int i = 0; i < 4; i++) begin
                if (be[i])
                    exp_mem[res[7:2]][8*i +: 8] = w[8*i +: 8];
            end
            st_cyc_q.push_back(cyc + 2);
            st_addr_q.push_back(res);
            st_be_q.push_back(be);
            st_data_q.push_back(w);
        end
        if (rw) begin
            wb_cyc_q.push_back(cyc + 3);
            wb_addr_q.push_back(rd);
            wb_data_q.push_back(res);
            if (rd != 0)
                model_regs[rd] = res;
        end
    endtask

    task automatic alu_instr(alu_op_t op, logic [4:0] rd, rs, rt, logic bs, logic [31:0] im);
        issue(op, SH_SLL, RES_ALU, rd, rs, rt, bs, im, 0, 0, 1, 0, 0, SIZE_WORD, 0);
    endtask

    task automatic shift_instr(shift_op_t op, logic [4:0] rd, rt, rs, logic ss, logic [4:0] sa);
        issue(OP_ADD, op, RES_SHIFT, rd, rs, rt, 0, 0, sa, ss, 1, 0, 0, SIZE_WORD, 0);
    endtask

    task automatic mem_instr(logic ld, mem_size_t sz, logic uns, logic [4:0] r,
                             logic [31:0] addr);
        issue(OP_ADD, SH_SLL, RES_ALU, ld ? r : 5'd0, 5'd0, ld ? 5'd0 : r, 1, addr,
              0, 0, ld, ld, !ld, sz, uns);
    endtask

    task automatic bubble(input int n);
        repeat (n) begin
            @(posedge clk);
            issue_valid <= 1'b0;
        end
    endtask

    // Let the pipeline empty, bounded by a timeout
    task automatic drain;
        int t;
        bubble(1);
        t = 0;
        while ((wb_cyc_q.size() != 0 || st_cyc_q.size() != 0) && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (wb_cyc_q.size() != 0 || st_cyc_q.size() != 0) begin
            $display("Timeout waiting for writebacks and stores to complete");
            errors++;
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic reset_state;
        @(negedge clk);
        check_value("mem_read", mem_read, 0);
        check_value("mem_write", mem_write, 0);
        check_value("wb_valid", wb_valid, 0);
        check_value("mem_byte_en", mem_byte_en, 0);
        alu_instr(OP_ADD, 3, 1, 2, 0, 0);
        drain();
    endtask

    task automatic alu_ops;
        for (int r = 1; r <= 8; r++)
            alu_instr(OP_ADD, r, 0, 0, 1, $urandom);
        for (int i = 0; i <= 8; i++) begin
            alu_instr(alu_op_t'(i), 10 + i, 1 + i % 8, 8 - i % 8, i == 8, $urandom);
            alu_instr(alu_op_t'(i), 20 + i % 4, 2 + i % 7, 0, 1, $urandom);
        end
        drain();
    endtask

    task automatic shift_ops;
        logic [4:0] amounts [4];
        amounts = '{0, 31, 5'($urandom), 5'($urandom)};
        for (int s = 0; s < 3; s++) begin
            foreach (amounts[j]) begin
                alu_instr(OP_ADD, 20, 0, 0, 1, $urandom | 32'h8000_0000);
                alu_instr(OP_ADD, 21, 0, 0, 1, ($urandom & 32'hffff_ffe0) | amounts[j]);
                shift_instr(shift_op_t'(s), 22, 20, 0, 0, amounts[j]);
                shift_instr(shift_op_t'(s), 23, 20, 21, 1, 0);
            end
        end
        drain();
    endtask

    task automatic forwarding_chains;
        for (int d = 0; d < 3; d++) begin
            alu_instr(OP_ADD, 1, 0, 0, 1, $urandom);
            alu_instr(OP_ADD, 2, 0, 0, 1, $urandom);
            for (int i = 0; i < 4; i++) begin
                alu_instr(OP_ADD, 1, 1, 2, 0, 0);
                bubble(d);
                alu_instr(OP_XOR, 2, 2, 1, 0, 0);
                bubble(d);
            end
            alu_instr(OP_ADD, 3, 2, 2, 0, 0);
            alu_instr(OP_ADD, 3, 3, 3, 0, 0);
        end
        // Register 0 stays zero after a write
        alu_instr(OP_ADD, 0, 0, 0, 1, $urandom | 1);
        alu_instr(OP_OR, 5, 0, 0, 0, 0);
        bubble(1);
        alu_instr(OP_OR, 6, 0, 0, 0, 0);
        drain();
    endtask

    task automatic store_lanes;
        logic [31:0] base;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                if ((s == 1 && off[0]) || (s == 2 && off != 0))
                    continue;
                base = ($urandom & 32'hfc) | off;
                alu_instr(OP_ADD, 9, 0, 0, 1, $urandom);
                mem_instr(0, mem_size_t'(s), 0, 9, base);
            end
        end
        drain();
    endtask

    task automatic load_extend;
        logic [31:0] addr;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom;
            exp_mem[i] = dmem[i];
        end
        alu_instr(OP_ADD, 7, 0, 0, 1, $urandom);
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                for (int u = 0; u < 2; u++) begin
                    if ((s == 1 && off[0]) || (s == 2 && (off != 0 || u == 1)))
                        continue;
                    addr = ($urandom & 32'hfc) | off;
                    mem_instr(1, mem_size_t'(s), u, 12, addr);
                    bubble(1);
                    alu_instr(OP_ADD, 13, 12, 7, 0, 0);
                end
            end
        end
        drain();
    endtask

    initial begin
        void'($urandom(32'h22cfe1f9));
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {i[15:0] ^ 16'ha5c3, ~i[15:0]};
            exp_mem[i] = dmem[i];
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        alu_ops();
        shift_ops();
        forwarding_chains();
        store_lanes();
        load_extend();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
